/* Makefile */
VERILATOR ?= verilator
TOP       ?= demodTop_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* common/adcCtrlIf.sv */
`default_nettype none

interface adcCtrlIf;

    // DAC configuration from the register block
    dspPkg::dacSelT dac0Sel;
    dspPkg::dacSelT dac1Sel;
    dspPkg::sampleT testSample;

    // Status back to the register block
    dspPkg::countT  ovfCount;

    modport regs (
        output dac0Sel, dac1Sel, testSample,
        input  ovfCount
    );

    modport path (
        input  dac0Sel, dac1Sel, testSample,
        output ovfCount
    );

endinterface

`default_nettype wire

/* common/cdCtrlIf.sv */
`default_nettype none

interface cdCtrlIf;

    // Per-channel stream select
    dspPkg::cdSelT ch0Sel;
    dspPkg::cdSelT ch1Sel;

    // Forwarded symbol counts
    dspPkg::countT ch0Count;
    dspPkg::countT ch1Count;

    modport regs (
        output ch0Sel, ch1Sel,
        input  ch0Count, ch1Count
    );

    modport router (
        input  ch0Sel, ch1Sel,
        output ch0Count, ch1Count
    );

endinterface

`default_nettype wire

/* common/dspPkg.sv */
`default_nettype none

package dspPkg;

    // **************************************************
    // Sample path types
    // **************************************************

    // Raw offset-binary code from the ADC
    typedef logic [13:0] adcCodeT;

    // Internal signed sample, ADC code left-justified
    typedef logic signed [17:0] sampleT;

    // Offset-binary code to the DAC
    typedef logic [13:0] dacCodeT;

    // DAC source select, code 3 gives midscale
    typedef logic [1:0] dacSelT;
    localparam dacSelT DAC_SRC_ADC  = 2'd0;
    localparam dacSelT DAC_SRC_TEST = 2'd1;
    localparam dacSelT DAC_SRC_MID  = 2'd2;

    // **************************************************
    // Clock-and-data types
    // **************************************************

    // Code 3 behaves as off
    typedef logic [1:0] cdSelT;
    localparam cdSelT CD_SRC_OFF = 2'd0;
    localparam cdSelT CD_SRC_I   = 2'd1;
    localparam cdSelT CD_SRC_Q   = 2'd2;

    // Status counters
    typedef logic [15:0] countT;

endpackage

`default_nettype wire

/* common/regMapPkg.sv */
`default_nettype none

package regMapPkg;

    // Bus widths
    typedef logic [7:0]  busAddrT;
    typedef logic [15:0] busDataT;

    localparam busDataT VERSION = 16'd454;

    // **************************************************
    // Register addresses
    // **************************************************

    // Read only
    localparam busAddrT ADDR_VERSION = 8'h00;

    // DAC0 in bits 1:0, DAC1 in bits 3:2
    localparam busAddrT ADDR_DAC_SEL = 8'h01;

    // Upper 16 bits of the 18-bit test sample
    localparam busAddrT ADDR_TEST_SAMPLE = 8'h02;

    // Channel 0 in bits 1:0, channel 1 in bits 3:2
    localparam busAddrT ADDR_CD_SEL = 8'h03;

    // Status counters, read only
    localparam busAddrT ADDR_OVF_COUNT = 8'h04;
    localparam busAddrT ADDR_CH0_COUNT = 8'h05;
    localparam busAddrT ADDR_CH1_COUNT = 8'h06;

    // Returned for any address outside the map
    localparam busDataT UNMAPPED_DATA = 16'h0000;

endpackage

`default_nettype wire

/* hw/adcPath/adcDacPath.sv */
`default_nettype none

module adcDacPath (
    input  wire                  clk,
    input  wire                  arstN,
    input  wire dspPkg::adcCodeT adc0,
    input  wire                  adc0Overflow,
    output dspPkg::dacCodeT      dac0Data,
    output dspPkg::dacCodeT      dac1Data,
    adcCtrlIf.path               ctrl
);

    // Source mux for one DAC, spare code falls to midscale
    function automatic dspPkg::sampleT pickSample(
        input dspPkg::dacSelT sel,
        input dspPkg::sampleT adcSample,
        input dspPkg::sampleT testSample
    );
        case (sel)
            dspPkg::DAC_SRC_ADC:  pickSample = adcSample;
            dspPkg::DAC_SRC_TEST: pickSample = testSample;
            default:              pickSample = '0;
        endcase
    endfunction

    // Back to offset binary, top 14 bits of the sample
    function automatic dspPkg::dacCodeT toDacCode(input dspPkg::sampleT sample);
        toDacCode = {~sample[17], sample[16:4]};
    endfunction

    // **************************************************
    // ADC reclock and signed conversion
    // **************************************************

    dspPkg::adcCodeT adcReg;
    dspPkg::sampleT  adcSample;

    always_ff @(posedge clk) begin
        adcReg    <= adc0;
        // Flip the MSB to go from offset binary to two's complement
        adcSample <= {~adcReg[13], adcReg[12:0], 4'b0000};
    end

    // **************************************************
    // DAC output registers
    // **************************************************

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            dac0Data <= '0;
            dac1Data <= '0;
        end else begin
            dac0Data <= toDacCode(pickSample(ctrl.dac0Sel, adcSample, ctrl.testSample));
            dac1Data <= toDacCode(pickSample(ctrl.dac1Sel, adcSample, ctrl.testSample));
        end
    end

    // Overflow flag, reclocked then counted
    logic ovfReg;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ovfReg        <= 1'b0;
            ctrl.ovfCount <= '0;
        end else begin
            ovfReg <= adc0Overflow;
            // Hold at full scale
            if (ovfReg && (ctrl.ovfCount != '1)) begin
                ctrl.ovfCount <= ctrl.ovfCount + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/clkData/clkDataRouter.sv */
`default_nettype none

module clkDataRouter (
    input  wire  clk,
    input  wire  arstN,
    input  wire  iSymEn,
    input  wire  iBit,
    input  wire  qSymEn,
    input  wire  qBit,
    output logic ch0ClkOut,
    output logic ch0DataOut,
    output logic ch1ClkOut,
    output logic ch1DataOut,
    cdCtrlIf.router ctrl
);

    // **************************************************
    // Per-channel stream routing
    // **************************************************

    for (genvar ch = 0; ch < 2; ch++) begin : genCh
        dspPkg::cdSelT sel;
        logic          symEn;
        logic          symBit;
        logic          clkQ;
        logic          dataQ;
        dspPkg::countT symCount;

        assign sel = (ch == 0) ? ctrl.ch0Sel : ctrl.ch1Sel;

        // Pick the strobe and bit, nothing when off
        always_comb begin
            case (sel)
                dspPkg::CD_SRC_I: begin
                    symEn  = iSymEn;
                    symBit = iBit;
                end
                dspPkg::CD_SRC_Q: begin
                    symEn  = qSymEn;
                    symBit = qBit;
                end
                default: begin
                    symEn  = 1'b0;
                    symBit = 1'b0;
                end
            endcase
        end

        // One-cycle clock pulse, data held between strobes
        always_ff @(posedge clk or negedge arstN) begin
            if (!arstN) begin
                clkQ     <= 1'b0;
                dataQ    <= 1'b0;
                symCount <= '0;
            end else begin
                clkQ <= symEn;
                if (symEn) begin
                    dataQ    <= symBit;
                    symCount <= symCount + 1'b1;
                end
            end
        end
    end

    assign ch0ClkOut     = genCh[0].clkQ;
    assign ch0DataOut    = genCh[0].dataQ;
    assign ch1ClkOut     = genCh[1].clkQ;
    assign ch1DataOut    = genCh[1].dataQ;
    assign ctrl.ch0Count = genCh[0].symCount;
    assign ctrl.ch1Count = genCh[1].symCount;

endmodule

`default_nettype wire

/* hw/demodRegs.sv */
`default_nettype none

module demodRegs (
    input  wire                     clk,
    input  wire                     arstN,
    input  wire                     busWrite,
    input  wire                     busRead,
    input  wire regMapPkg::busAddrT busAddr,
    input  wire regMapPkg::busDataT busWrData,
    output regMapPkg::busDataT      busRdData,
    output logic                    busRdValid,
    adcCtrlIf.regs                  adcCtrl,
    cdCtrlIf.regs                   cdCtrl
);

    // **************************************************
    // Configuration writes
    // **************************************************

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            adcCtrl.dac0Sel    <= dspPkg::DAC_SRC_ADC;
            adcCtrl.dac1Sel    <= dspPkg::DAC_SRC_ADC;
            adcCtrl.testSample <= '0;
            cdCtrl.ch0Sel      <= dspPkg::CD_SRC_OFF;
            cdCtrl.ch1Sel      <= dspPkg::CD_SRC_OFF;
        end else if (busWrite) begin
            // Read-only and unmapped addresses fall through
            case (busAddr)
                regMapPkg::ADDR_DAC_SEL: begin
                    adcCtrl.dac0Sel <= busWrData[1:0];
                    adcCtrl.dac1Sel <= busWrData[3:2];
                end
                regMapPkg::ADDR_TEST_SAMPLE: begin
                    adcCtrl.testSample <= {busWrData, 2'b00};
                end
                regMapPkg::ADDR_CD_SEL: begin
                    cdCtrl.ch0Sel <= busWrData[1:0];
                    cdCtrl.ch1Sel <= busWrData[3:2];
                end
                default: begin
                end
            endcase
        end
    end

    // **************************************************
    // Read mux
    // **************************************************

    regMapPkg::busDataT rdMux;

    always_comb begin
        case (busAddr)
            regMapPkg::ADDR_VERSION:     rdMux = regMapPkg::VERSION;
            regMapPkg::ADDR_DAC_SEL:     rdMux = {12'h000, adcCtrl.dac1Sel, adcCtrl.dac0Sel};
            regMapPkg::ADDR_TEST_SAMPLE: rdMux = adcCtrl.testSample[17:2];
            regMapPkg::ADDR_CD_SEL:      rdMux = {12'h000, cdCtrl.ch1Sel, cdCtrl.ch0Sel};
            regMapPkg::ADDR_OVF_COUNT:   rdMux = adcCtrl.ovfCount;
            regMapPkg::ADDR_CH0_COUNT:   rdMux = cdCtrl.ch0Count;
            regMapPkg::ADDR_CH1_COUNT:   rdMux = cdCtrl.ch1Count;
            default:                     rdMux = regMapPkg::UNMAPPED_DATA;
        endcase
    end

    // Response one cycle after the strobe
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            busRdValid <= 1'b0;
        end else begin
            busRdValid <= busRead;
        end
    end

    always_ff @(posedge clk) begin
        if (busRead) begin
            busRdData <= rdMux;
        end
    end

endmodule

`default_nettype wire

/* hw/demodTop.sv */
`default_nettype none

module demodTop (
    input  wire                     clk,
    input  wire                     arstN,
    // Register bus
    input  wire                     busWrite,
    input  wire                     busRead,
    input  wire regMapPkg::busAddrT busAddr,
    input  wire regMapPkg::busDataT busWrData,
    output regMapPkg::busDataT      busRdData,
    output logic                    busRdValid,
    // ADC and DACs
    input  wire dspPkg::adcCodeT    adc0,
    input  wire                     adc0Overflow,
    output dspPkg::dacCodeT         dac0Data,
    output dspPkg::dacCodeT         dac1Data,
    // Demod symbol streams
    input  wire                     iSymEn,
    input  wire                     iBit,
    input  wire                     qSymEn,
    input  wire                     qBit,
    // Clock-and-data outputs
    output logic                    ch0ClkOut,
    output logic                    ch0DataOut,
    output logic                    ch1ClkOut,
    output logic                    ch1DataOut
);

    adcCtrlIf adcCtrl ();
    cdCtrlIf  cdCtrl ();

    // **************************************************
    // Register block
    // **************************************************

    demodRegs regs_i (
        .clk        (clk),
        .arstN      (arstN),
        .busWrite   (busWrite),
        .busRead    (busRead),
        .busAddr    (busAddr),
        .busWrData  (busWrData),
        .busRdData  (busRdData),
        .busRdValid (busRdValid),
        .adcCtrl    (adcCtrl.regs),
        .cdCtrl     (cdCtrl.regs)
    );

    // **************************************************
    // Sample path and symbol routing
    // **************************************************

    adcDacPath adcPath_i (
        .clk          (clk),
        .arstN        (arstN),
        .adc0         (adc0),
        .adc0Overflow (adc0Overflow),
        .dac0Data     (dac0Data),
        .dac1Data     (dac1Data),
        .ctrl         (adcCtrl.path)
    );

    clkDataRouter router_i (
        .clk        (clk),
        .arstN      (arstN),
        .iSymEn     (iSymEn),
        .iBit       (iBit),
        .qSymEn     (qSymEn),
        .qBit       (qBit),
        .ch0ClkOut  (ch0ClkOut),
        .ch0DataOut (ch0DataOut),
        .ch1ClkOut  (ch1ClkOut),
        .ch1DataOut (ch1DataOut),
        .ctrl       (cdCtrl.router)
    );

endmodule

`default_nettype wire

/* tb/demodTop_properties.sv */
`default_nettype none

module demodTop_properties (
    input wire                clk,
    input wire                arstN,
    input wire                busRead,
    input wire                busRdValid,
    input wire                ch0ClkOut,
    input wire                ch1ClkOut,
    input wire dspPkg::cdSelT ch0Sel,
    input wire dspPkg::cdSelT ch1Sel
);

    // Read response exactly one cycle after the strobe
    rdValidFollowsRead: assert property (@(posedge clk) disable iff (!arstN)
        busRdValid == $past(busRead))
        else $error("busRdValid does not follow the read strobe by one cycle");

    // **************************************************
    // Clock pulse shape
    // **************************************************

    ch0SinglePulse: assert property (@(posedge clk) disable iff (!arstN)
        ch0ClkOut |=> !ch0ClkOut)
        else $error("ch0ClkOut high for two cycles in a row");

    ch1SinglePulse: assert property (@(posedge clk) disable iff (!arstN)
        ch1ClkOut |=> !ch1ClkOut)
        else $error("ch1ClkOut high for two cycles in a row");

    // Codes 0 and 3 both mean off
    ch0NoPulseWhenOff: assert property (@(posedge clk) disable iff (!arstN)
        ch0ClkOut |-> ($past(ch0Sel) == dspPkg::CD_SRC_I || $past(ch0Sel) == dspPkg::CD_SRC_Q))
        else $error("ch0ClkOut pulsed while channel 0 was off");

    ch1NoPulseWhenOff: assert property (@(posedge clk) disable iff (!arstN)
        ch1ClkOut |-> ($past(ch1Sel) == dspPkg::CD_SRC_I || $past(ch1Sel) == dspPkg::CD_SRC_Q))
        else $error("ch1ClkOut pulsed while channel 1 was off");

endmodule

// Register block only carries the bus side
bind demodRegs demodTop_properties regsProps_i (
    .clk        (clk),
    .arstN      (arstN),
    .busRead    (busRead),
    .busRdValid (busRdValid),
    .ch0ClkOut  (1'b0),
    .ch1ClkOut  (1'b0),
    .ch0Sel     (dspPkg::CD_SRC_OFF),
    .ch1Sel     (dspPkg::CD_SRC_OFF)
);

bind clkDataRouter demodTop_properties routerProps_i (
    .clk        (clk),
    .arstN      (arstN),
    .busRead    (1'b0),
    .busRdValid (1'b0),
    .ch0ClkOut  (ch0ClkOut),
    .ch1ClkOut  (ch1ClkOut),
    .ch0Sel     (ctrl.ch0Sel),
    .ch1Sel     (ctrl.ch1Sel)
);

`default_nettype wire

/* tb/demodTop_tb.sv */
`default_nettype none

module demodTop_tb;

    localparam int RESET_CYCLES  = 16;
    localparam int RD_TIMEOUT    = 20;
    localparam int STREAM_CYCLES = 60;

    logic               clk;
    logic               arstN;
    logic               busWrite;
    logic               busRead;
    regMapPkg::busAddrT busAddr;
    regMapPkg::busDataT busWrData;
    regMapPkg::busDataT busRdData;
    logic               busRdValid;
    dspPkg::adcCodeT    adc0;
    logic               adc0Overflow;
    dspPkg::dacCodeT    dac0Data;
    dspPkg::dacCodeT    dac1Data;
    logic               iSymEn;
    logic               iBit;
    logic               qSymEn;
    logic               qBit;
    logic               ch0ClkOut;
    logic               ch0DataOut;
    logic               ch1ClkOut;
    logic               ch1DataOut;

    integer seed;
    int     checkCount;
    int     errorCount;
    int     timeoutCount;
    // Model state: last forwarded bit and symbols forwarded per channel
    logic   lastData0;
    logic   lastData1;
    int     ch0Total;
    int     ch1Total;

    demodTop dut_i (.*);

    always #50 clk = ~clk;

    function automatic int randBelow(input int n);
        randBelow = {$random(seed)} % n;
    endfunction

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("** Error [%s] expected 0x%0h, actual 0x%0h", testName, expected, actual);
        end
    endtask

    // **************************************************
    // Bus helpers
    // **************************************************

    task automatic writeReg(input regMapPkg::busAddrT addr, input regMapPkg::busDataT data);
        @(negedge clk);
        busWrite  = 1'b1;
        busAddr   = addr;
        busWrData = data;
        @(negedge clk);
        busWrite = 1'b0;
    endtask

    task automatic readReg(input regMapPkg::busAddrT addr, output regMapPkg::busDataT data);
        int waitCount;
        @(negedge clk);
        busRead = 1'b1;
        busAddr = addr;
        @(negedge clk);
        busRead   = 1'b0;
        waitCount = 0;
        while (!busRdValid && waitCount < RD_TIMEOUT) begin
            @(negedge clk);
            waitCount++;
        end
        if (busRdValid) begin
            data = busRdData;
        end else begin
            timeoutCount++;
            data = 'x;
            $display("Read of address 0x%0h got no response within %0d cycles", addr, RD_TIMEOUT);
        end
    endtask

    task automatic checkReg(input string testName, input regMapPkg::busAddrT addr,
                            input logic [31:0] expected);
        regMapPkg::busDataT data;
        readReg(addr, data);
        checkValue(testName, expected, data);
    endtask

    // **************************************************
    // Directed tests
    // **************************************************

    task automatic testResetVersion();
        checkReg("resetVersion", regMapPkg::ADDR_VERSION, 454);
        checkReg("resetVersion", regMapPkg::ADDR_DAC_SEL, 0);
        checkReg("resetVersion", regMapPkg::ADDR_TEST_SAMPLE, 0);
        checkReg("resetVersion", regMapPkg::ADDR_CD_SEL, 0);
        checkReg("resetVersion", regMapPkg::ADDR_OVF_COUNT, 0);
        checkReg("resetVersion", regMapPkg::ADDR_CH0_COUNT, 0);
        checkReg("resetVersion", regMapPkg::ADDR_CH1_COUNT, 0);
        checkReg("resetVersion", 8'h5A, 16'h0000);
    endtask

    task automatic testAdcToDac();
        dspPkg::adcCodeT sent[40];
        writeReg(regMapPkg::ADDR_DAC_SEL, 16'h0000);
        // Output lags the driven code by three edges
        for (int cyc = 0; cyc < 43; cyc++) begin
            @(negedge clk);
            if (cyc >= 3) begin
                checkValue("adcToDac", sent[cyc - 3], dac0Data);
                checkValue("adcToDac", sent[cyc - 3], dac1Data);
            end
            if (cyc < 40) begin
                sent[cyc] = dspPkg::adcCodeT'($random(seed));
                adc0      = sent[cyc];
            end
        end
    endtask

    task automatic testTestSample();
        regMapPkg::busDataT ts;
        ts = regMapPkg::busDataT'($random(seed));
        writeReg(regMapPkg::ADDR_TEST_SAMPLE, ts);
        writeReg(regMapPkg::ADDR_DAC_SEL, 16'h0009);
        @(negedge clk);
        checkValue("testSample", {~ts[15], ts[14:2]}, dac0Data);
        checkValue("testSample", 14'h2000, dac1Data);
        checkReg("testSample", regMapPkg::ADDR_TEST_SAMPLE, ts);
        // Spare select code
        writeReg(regMapPkg::ADDR_DAC_SEL, 16'h000F);
        @(negedge clk);
        checkValue("testSample", 14'h2000, dac0Data);
    endtask

    task automatic testOverflow();
        int pulses;
        pulses = 5 + randBelow(8);
        for (int p = 0; p < pulses; p++) begin
            @(negedge clk);
            adc0Overflow = 1'b1;
            @(negedge clk);
            adc0Overflow = 1'b0;
            repeat (randBelow(4)) @(negedge clk);
        end
        @(negedge clk);
        checkReg("overflow", regMapPkg::ADDR_OVF_COUNT, pulses);
    endtask

    // Random strobes, each stream idles at least one cycle between symbols
    task automatic runStreams(input string testName, input logic ch0OnQ, input logic ch1On);
        logic exp0;
        logic exp1;
        for (int cyc = 0; cyc <= STREAM_CYCLES; cyc++) begin
            @(negedge clk);
            exp0 = ch0OnQ ? qSymEn : iSymEn;
            exp1 = ch1On & qSymEn;
            if (exp0) begin
                lastData0 = ch0OnQ ? qBit : iBit;
                ch0Total++;
            end
            if (exp1) begin
                lastData1 = qBit;
                ch1Total++;
            end
            checkValue(testName, exp0, ch0ClkOut);
            checkValue(testName, exp1, ch1ClkOut);
            checkValue(testName, lastData0, ch0DataOut);
            checkValue(testName, lastData1, ch1DataOut);
            iSymEn = (cyc < STREAM_CYCLES) && !iSymEn && (randBelow(2) == 0);
            qSymEn = (cyc < STREAM_CYCLES) && !qSymEn && (randBelow(2) == 0);
            iBit   = 1'(randBelow(2));
            qBit   = 1'(randBelow(2));
        end
    endtask

    task automatic testRouting();
        writeReg(regMapPkg::ADDR_CD_SEL, 16'h0009);
        runStreams("routing", 1'b0, 1'b1);
        checkReg("routing", regMapPkg::ADDR_CH0_COUNT, ch0Total);
        checkReg("routing", regMapPkg::ADDR_CH1_COUNT, ch1Total);
    endtask

    task automatic testChannelOff();
        // Channel 1 off, channel 0 moves to Q
        writeReg(regMapPkg::ADDR_CD_SEL, 16'h0002);
        runStreams("channelOff", 1'b1, 1'b0);
        checkReg("channelOff", regMapPkg::ADDR_CH0_COUNT, ch0Total);
        checkReg("channelOff", regMapPkg::ADDR_CH1_COUNT, ch1Total);
    endtask

    initial begin
        seed         = 22972;
        checkCount   = 0;
        errorCount   = 0;
        timeoutCount = 0;
        lastData0    = 1'b0;
        lastData1    = 1'b0;
        ch0Total     = 0;
        ch1Total     = 0;
        clk          = 1'b0;
        arstN        = 1'b0;
        busWrite     = 1'b0;
        busRead      = 1'b0;
        busAddr      = '0;
        busWrData    = '0;
        adc0         = '0;
        adc0Overflow = 1'b0;
        iSymEn       = 1'b0;
        iBit         = 1'b0;
        qSymEn       = 1'b0;
        qBit         = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;

        testResetVersion();
        testAdcToDac();
        testTestSample();
        testOverflow();
        testRouting();
        testChannelOff();

        @(negedge clk);
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checkCount, errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
common/dspPkg.sv
common/regMapPkg.sv
common/adcCtrlIf.sv
common/cdCtrlIf.sv
hw/adcPath/adcDacPath.sv
hw/clkData/clkDataRouter.sv
hw/demodRegs.sv
hw/demodTop.sv
tb/demodTop_properties.sv
tb/demodTop_tb.sv
